//--- source/dspPkg.sv
// ###############################################
// one 16-bit ADC word per 16-cycle frame on sck
// rate window sized for 10 s at a 40 MHz sck
// ###############################################
package dspPkg;

	// ADC framing, one bit per sck cycle
	localparam int frameBits = 16;
	typedef logic [3:0] frameCountT;
	typedef logic [frameBits-1:0] adcWordT;

	// sample is the low 10 bits of the word
	localparam int sampleWidth = 10;
	typedef logic [sampleWidth-1:0] sampleT;

	// symmetric low-pass, coefficients scaled by 1024
	localparam int firTaps = 31;
	localparam int firShift = 10;
	// half filter, last entry is the centre tap
	localparam int firCoefs [firTaps/2+1] = '{
		3, 4, 6, 8, 12, 17, 23, 29, 36, 43, 50, 56, 61, 65, 67, 68
	};
	typedef logic [17:0] firAccT;

	// slope window peak detection
	localparam int slopeWindow = 256;
	typedef logic [7:0] slopeHalfT;
	localparam int peakLeftMax = 60;
	localparam int peakRightMin = 60;
	localparam int peakHoldFrames = 256;
	typedef enum logic {armed, holding} peakStateT;

	// beats per minute from peaks in a 10 s window
	localparam int rateWindowFrames = 25_000_000;
	localparam int ratePerPeak = 6;
	typedef logic [11:0] rateT;

endpackage

//--- source/ioPkg.sv
// ###############################################
// segments are active low, DAC channel and range fixed
// ###############################################
package ioPkg;

	// DAC command: channel, range, then 8 data bits
	localparam int dacWordBits = 11;
	localparam logic [1:0] dacChannel = 2'd0;
	localparam logic dacRange = 1'b0;
	typedef enum logic [1:0] {idle, shifting, latching} dacPhaseT;

	typedef struct packed {
		logic serial;
		logic load;
		logic ldac;
	} dacPinsT;

	// gfedcba, low lights the segment
	typedef logic [6:0] segmentT;
	localparam segmentT segmentPatterns [16] = '{
		7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000,
		7'b001_1001, 7'b001_0010, 7'b000_0010, 7'b111_1000,
		7'b000_0000, 7'b001_1000, 7'b000_1000, 7'b000_0011,
		7'b010_0111, 7'b010_0001, 7'b000_0110, 7'b000_1110
	};

	typedef struct packed {
		segmentT seven13;
		segmentT seven2;
		logic disp1;
		logic disp3;
	} displayPinsT;

	// sck cycles per multiplex phase
	localparam int displayToggleCycles = 250_000;

endpackage

//--- source/spiSampleReceiver.sv
// ###############################################
// ADC word arrives MSB first, frame aligned to reset
// ###############################################
`timescale 1ns/1ns

module spiSampleReceiver (
	input logic sck,
	input logic reset,
	input logic sdo,
	output dspPkg::sampleT sample,
	output logic sampleStrobe
);
	import dspPkg::*;

	frameCountT frameCount;
	adcWordT shiftReg;
	adcWordT word;
	logic frameEnd;

	// word including the bit arriving on this edge
	assign word = {shiftReg[frameBits-2:0], sdo};
	assign frameEnd = (frameCount == frameCountT'(frameBits - 1));

	// frame position, wraps every 16 cycles
	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			frameCount <= '0;
			sampleStrobe <= 1'b0;
		end
		else
		begin
			frameCount <= frameCount + 1'b1;
			// one strobe per frame, the cycle after the last bit
			sampleStrobe <= frameEnd;
		end

	// serial-in register and sample capture
	always_ff @(posedge sck)
	begin
		shiftReg <= word;
		if (frameEnd)
			sample <= word[sampleWidth-1:0];
	end

endmodule

//--- source/firFilter.sv
// ###############################################
// 18-bit accumulator wraps, output is acc >> 10
// ###############################################
`timescale 1ns/1ns

module firFilter (
	input logic sck,
	input logic reset,
	input dspPkg::sampleT sample,
	input logic sampleStrobe,
	output dspPkg::sampleT filtered,
	output logic filterStrobe
);
	import dspPkg::*;

	// 30 older samples, index 0 newest
	sampleT taps [firTaps-1];
	// full 31-tap view once the new sample is in
	sampleT nextTaps [firTaps];
	firAccT acc;

	always_comb
	begin
		nextTaps[0] = sample;
		for (int i = 1; i < firTaps; i++)
			nextTaps[i] = taps[i-1];
	end

	// symmetric sum, pair add first then one multiply per pair
	always_comb
	begin
		acc = '0;
		for (int k = 0; k < firTaps / 2; k++)
			acc = acc + (firAccT'(nextTaps[k]) + firAccT'(nextTaps[firTaps-1-k]))
				* firAccT'(firCoefs[k]);
		// centre tap stands alone
		acc = acc + firAccT'(nextTaps[firTaps/2]) * firAccT'(firCoefs[firTaps/2]);
	end

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			for (int i = 0; i < firTaps - 1; i++)
				taps[i] <= '0;
			filterStrobe <= 1'b0;
		end
		else
		begin
			filterStrobe <= sampleStrobe;
			// delay line advances once per frame
			if (sampleStrobe)
				taps <= nextTaps[0:firTaps-2];
		end

	// scaled result, valid with filterStrobe
	always_ff @(posedge sck)
		if (sampleStrobe)
			filtered <= sampleT'(acc >> firShift);

endmodule

//--- source/peakDetector.sv
// ###############################################
// peak = falling slope after rising, LED holds 256 frames
// ###############################################
`timescale 1ns/1ns

module peakDetector (
	input logic sck,
	input logic reset,
	input dspPkg::sampleT filtered,
	input logic filterStrobe,
	output logic peakPulse,
	output logic peakLed
);
	import dspPkg::*;

	typedef logic [$clog2(peakHoldFrames)-1:0] holdCountT;

	sampleT prevSample;
	logic slopeBit;
	// bit 0 newest, upper half is the older half
	logic [slopeWindow-1:0] window;
	slopeHalfT leftSum;
	slopeHalfT rightSum;
	slopeHalfT leftNext;
	slopeHalfT rightNext;
	peakStateT state;
	holdCountT holdCount;
	logic found;

	// 1 when not rising
	assign slopeBit = (filtered <= prevSample);

	// ones counts after the new bit enters
	assign rightNext = rightSum + slopeHalfT'(slopeBit)
		- slopeHalfT'(window[slopeWindow/2-1]);
	assign leftNext = leftSum + slopeHalfT'(window[slopeWindow/2-1])
		- slopeHalfT'(window[slopeWindow-1]);

	// few falls in the older half, many in the newer half
	assign found = (state == armed) && (leftNext <= slopeHalfT'(peakLeftMax))
		&& (rightNext >= slopeHalfT'(peakRightMin));
	assign peakLed = (state == holding);

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			prevSample <= '0;
			window <= '1;
			leftSum <= slopeHalfT'(slopeWindow / 2);
			rightSum <= slopeHalfT'(slopeWindow / 2);
			state <= armed;
			holdCount <= '0;
			peakPulse <= 1'b0;
		end
		else
		begin
			peakPulse <= filterStrobe && found;
			if (filterStrobe)
			begin
				prevSample <= filtered;
				window <= {window[slopeWindow-2:0], slopeBit};
				leftSum <= leftNext;
				rightSum <= rightNext;
				case (state)
					armed:
						if (found)
						begin
							state <= holding;
							holdCount <= '0;
						end
					holding:
						// counts frames with the LED lit
						if (holdCount == holdCountT'(peakHoldFrames - 1))
							state <= armed;
						else
							holdCount <= holdCount + 1'b1;
					default:
						state <= armed;
				endcase
			end
		end

endmodule

//--- source/dacSerializer.sv
// ###############################################
// 11-bit command MSB first, load low one cycle after
// ###############################################
`timescale 1ns/1ns

module dacSerializer (
	input logic sck,
	input logic reset,
	input dspPkg::sampleT filtered,
	input logic filterStrobe,
	output ioPkg::dacPinsT dacPins
);
	import ioPkg::*;

	dacPhaseT phase;
	logic [dacWordBits-1:0] word;
	logic [dacWordBits-1:0] shiftReg;
	logic [3:0] bitCount;
	logic serialBit;
	logic loadBit;

	// channel, range, low 8 data bits
	assign word = {dacChannel, dacRange, filtered[7:0]};

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			phase <= idle;
			bitCount <= '0;
			serialBit <= 1'b0;
			loadBit <= 1'b1;
		end
		else
			case (phase)
				idle:
					if (filterStrobe)
					begin
						// MSB goes out in the next cycle
						serialBit <= word[dacWordBits-1];
						bitCount <= '0;
						phase <= shifting;
					end
				shifting:
					if (bitCount == 4'(dacWordBits - 1))
					begin
						// all bits out, latch the word
						serialBit <= 1'b0;
						loadBit <= 1'b0;
						phase <= latching;
					end
					else
					begin
						serialBit <= shiftReg[dacWordBits-2];
						bitCount <= bitCount + 1'b1;
					end
				latching:
				begin
					loadBit <= 1'b1;
					phase <= idle;
				end
				default:
					phase <= idle;
			endcase

	always_ff @(posedge sck)
		if (phase == idle && filterStrobe)
			shiftReg <= word;
		else if (phase == shifting)
			shiftReg <= {shiftReg[dacWordBits-2:0], 1'b0};

	// ldac tied low, DAC updates on load
	assign dacPins = '{serial: serialBit, load: loadBit, ldac: 1'b0};

endmodule

//--- source/rateCounter.sv
// ###############################################
// back-to-back windows, rate = peaks * 6, no warm-up
// rate moves two cycles after the window's last strobe
// ###############################################
`timescale 1ns/1ns

module rateCounter #(
	parameter int windowFrames = dspPkg::rateWindowFrames
) (
	input logic sck,
	input logic reset,
	input logic filterStrobe,
	input logic peakPulse,
	output dspPkg::rateT rate
);
	import dspPkg::*;

	typedef logic [$clog2(windowFrames)-1:0] windowCountT;

	windowCountT frameCount;
	rateT peakCount;
	// filterStrobe one cycle late, in step with peakPulse
	logic frameDone;
	logic windowEnd;

	// last frame of the window
	assign windowEnd = frameDone && (frameCount == windowCountT'(windowFrames - 1));

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			frameDone <= 1'b0;
			frameCount <= '0;
			peakCount <= '0;
			rate <= '0;
		end
		else
		begin
			frameDone <= filterStrobe;
			if (windowEnd)
			begin
				// the last frame's own peak still counts
				rate <= rateT'((peakCount + rateT'(peakPulse)) * rateT'(ratePerPeak));
				frameCount <= '0;
				peakCount <= '0;
			end
			else
			begin
				if (frameDone)
					frameCount <= frameCount + 1'b1;
				if (peakPulse)
					peakCount <= peakCount + 1'b1;
			end
		end

endmodule

//--- source/displayDriver.sv
// ###############################################
// rate shown as three hex nibbles on two digits
// ###############################################
`timescale 1ns/1ns

module displayDriver (
	input logic sck,
	input logic reset,
	input dspPkg::rateT rate,
	output ioPkg::displayPinsT displayPins
);
	import ioPkg::*;

	typedef logic [$clog2(displayToggleCycles)-1:0] toggleCountT;

	toggleCountT toggleCount;
	// 0 shows the low nibble, 1 the high nibble
	logic phase;
	logic [3:0] sharedNibble;

	// phase flips every displayToggleCycles cycles
	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			toggleCount <= '0;
			phase <= 1'b0;
		end
		else if (toggleCount == toggleCountT'(displayToggleCycles - 1))
		begin
			toggleCount <= '0;
			phase <= ~phase;
		end
		else
			toggleCount <= toggleCount + 1'b1;

	// seven13 is shared by digits 1 and 3
	assign sharedNibble = phase ? rate[11:8] : rate[3:0];

	assign displayPins.seven13 = segmentPatterns[sharedNibble];
	// middle nibble always on its own digit
	assign displayPins.seven2 = segmentPatterns[rate[7:4]];
	assign displayPins.disp1 = phase;
	assign displayPins.disp3 = ~phase;

endmodule

//--- source/heartRateMonitor.sv
// ###############################################
// single clock sck, windowFrames shortens the rate window
// ###############################################
`timescale 1ns/1ns

module heartRateMonitor #(
	parameter int windowFrames = dspPkg::rateWindowFrames
) (
	input logic sck,
	input logic reset,
	input logic sdo,
	output logic peakLed,
	output ioPkg::dacPinsT dacPins,
	output ioPkg::displayPinsT displayPins
);
	import dspPkg::*;

	sampleT sample;
	logic sampleStrobe;
	sampleT filtered;
	logic filterStrobe;
	logic peakPulse;
	rateT rate;

	// ADC frame in, one sample per frame
	spiSampleReceiver receiver (
		.sck(sck),
		.reset(reset),
		.sdo(sdo),
		.sample(sample),
		.sampleStrobe(sampleStrobe)
	);

	firFilter lowPass (
		.sck(sck),
		.reset(reset),
		.sample(sample),
		.sampleStrobe(sampleStrobe),
		.filtered(filtered),
		.filterStrobe(filterStrobe)
	);

	// filtered sample feeds both the DAC and the detector
	dacSerializer dac (
		.sck(sck),
		.reset(reset),
		.filtered(filtered),
		.filterStrobe(filterStrobe),
		.dacPins(dacPins)
	);

	peakDetector peaks (
		.sck(sck),
		.reset(reset),
		.filtered(filtered),
		.filterStrobe(filterStrobe),
		.peakPulse(peakPulse),
		.peakLed(peakLed)
	);

	rateCounter #(
		.windowFrames(windowFrames)
	) rateCount (
		.sck(sck),
		.reset(reset),
		.filterStrobe(filterStrobe),
		.peakPulse(peakPulse),
		.rate(rate)
	);

	displayDriver display (
		.sck(sck),
		.reset(reset),
		.rate(rate),
		.displayPins(displayPins)
	);

endmodule

//--- sim/heartRateChecker.sv
// ###############################################
// sample points assume frame 0 starts right after reset
// display phase never flips in a run this short
// ###############################################
`timescale 1ns/1ns

module heartRateChecker #(
	parameter int frames = 700,
	parameter int windowLen = 256
) (
	input logic sck,
	input logic reset,
	input logic peakLed,
	input ioPkg::dacPinsT dacPins,
	input ioPkg::displayPinsT displayPins,
	input dspPkg::sampleT expFir [frames],
	input logic expLed [frames],
	input dspPkg::rateT expRate [frames],
	output logic done,
	output int checks,
	output int errors
);
	import dspPkg::*;
	import ioPkg::*;

	// filterStrobe of frame 0, counted from the first cycle out of reset
	localparam int strobeCycle = frameBits + 1;
	// 11 serial bits, then load low
	localparam int loadCycle = strobeCycle + dacWordBits + 1;
	// rate lands once the last frame's peakPulse is in
	localparam int rateCycle = strobeCycle + 2;
	// load pulse sits mid slot
	localparam int slotStart = loadCycle - frameBits / 2;

	int cyc;
	int frame;
	int loadsInSlot;
	int testChecks [5];
	int testErrors [5];
	string where;
	logic [dacWordBits-1:0] serialHist;
	logic [3:0] shownNibble;
	segmentT prevSeven13;
	logic prevDisp1;
	logic rateStep;

	function automatic string testName(input int t);
		case (t)
			0: return "reset state";
			1: return "DAC words";
			2: return "peak LED";
			3: return "rate display";
			default: return "display invariants";
		endcase
	endfunction

	task automatic compareValue(input int t, input string name, input string at,
		input int got, input int want);
		testChecks[t]++;
		if (got != want)
		begin
			testErrors[t]++;
			$display("[FAIL] %s %s: got 0x%0h, expected 0x%0h", name, at, got, want);
		end
	endtask

	task automatic expectTrue(input int t, input logic ok, input string text);
		testChecks[t]++;
		if (!ok)
		begin
			testErrors[t]++;
			$display("%s", text);
		end
	endtask

	task automatic printTest(input int t);
		$display("test %0d %s: %0d checks, %0d errors", t + 1, testName(t),
			testChecks[t], testErrors[t]);
	endtask

	always @(negedge sck)
		if (reset)
		begin
			cyc = 0;
			loadsInSlot = 0;
			done = 1'b0;
			checks = 0;
			errors = 0;
			serialHist = '0;
			prevSeven13 = '0;
			prevDisp1 = 1'b0;
			for (int t = 0; t < 5; t++)
			begin
				testChecks[t] = 0;
				testErrors[t] = 0;
			end
		end
		else if (!done)
		begin
			// first cycle out of reset, no filterStrobe yet
			if (cyc == 0)
			begin
				compareValue(0, "peakLed", "at reset", int'(peakLed), 0);
				compareValue(0, "load", "at reset", int'(dacPins.load), 1);
				compareValue(0, "ldac", "at reset", int'(dacPins.ldac), 0);
				compareValue(0, "seven13", "at reset", int'(displayPins.seven13),
					int'(segmentPatterns[0]));
				compareValue(0, "seven2", "at reset", int'(displayPins.seven2),
					int'(segmentPatterns[0]));
				expectTrue(0, displayPins.disp1 != displayPins.disp3,
					"disp1 and disp3 are not complementary after reset");
				printTest(0);
			end

			// slot boundary, exactly one load pulse per frame
			if (cyc >= slotStart + frameBits && (cyc - slotStart) % frameBits == 0)
			begin
				frame = (cyc - slotStart) / frameBits - 1;
				expectTrue(1, loadsInSlot == 1, loadsInSlot == 0
					? $sformatf("no DAC load pulse seen in frame %0d", frame)
					: $sformatf("%0d DAC load pulses seen in frame %0d", loadsInSlot, frame));
				loadsInSlot = 0;
				if (frame == frames - 1)
				begin
					for (int t = 1; t < 5; t++)
						printTest(t);
					for (int t = 0; t < 5; t++)
					begin
						checks += testChecks[t];
						errors += testErrors[t];
					end
					done = 1'b1;
				end
			end

			if (!dacPins.load)
			begin
				loadsInSlot++;
				frame = (cyc - slotStart) / frameBits;
				if (cyc >= slotStart && frame < frames)
				begin
					where = $sformatf("frame %0d", frame);
					// channel 0 and range 0 ahead of the data byte
					compareValue(1, "dacWord", where, int'(serialHist),
						int'({3'b000, expFir[frame][7:0]}));
					compareValue(2, "peakLed", where, int'(peakLed), int'(expLed[frame]));
					shownNibble = displayPins.disp1 ? expRate[frame][11:8] : expRate[frame][3:0];
					compareValue(3, "seven13", where, int'(displayPins.seven13),
						int'(segmentPatterns[shownNibble]));
					compareValue(3, "seven2", where, int'(displayPins.seven2),
						int'(segmentPatterns[expRate[frame][7:4]]));
				end
			end

			// rate may only move two cycles after a window's last strobe
			rateStep = cyc >= rateCycle && (cyc - rateCycle) % frameBits == 0
				&& ((cyc - rateCycle) / frameBits + 1) % windowLen == 0;
			expectTrue(4, displayPins.disp1 != displayPins.disp3,
				$sformatf("disp1 and disp3 equal at cycle %0d", cyc));
			if (cyc > 0)
				expectTrue(4, displayPins.seven13 == prevSeven13
					|| displayPins.disp1 != prevDisp1 || rateStep,
					$sformatf("seven13 changed at cycle %0d with no digit or rate change", cyc));

			serialHist = {serialHist[dacWordBits-2:0], dacPins.serial};
			prevSeven13 = displayPins.seven13;
			prevDisp1 = displayPins.disp1;
			cyc++;
		end

endmodule

//--- sim/tbHeartRate.sv
// ###############################################
// samples kept at or below 255 so the 18-bit FIR sum never wraps
// short 256-frame rate window
// ###############################################
`timescale 1ns/1ns

module tbHeartRate;
	import dspPkg::*;

	localparam int frameTotal = 700;
	localparam int windowLen = 256;
	localparam int resetCycles = 10;
	// every frame plus 10 percent, plus the reset
	localparam int cycleLimit = frameTotal * frameBits * 11 / 10 + resetCycles;

	logic sck;
	logic reset;
	logic sdo;
	logic peakLed;
	ioPkg::dacPinsT dacPins;
	ioPkg::displayPinsT displayPins;
	logic done;
	int checks;
	int errors;
	int cycles = 0;

	adcWordT words [frameTotal];
	sampleT samples [frameTotal];
	sampleT firOut [frameTotal];
	logic peakAt [frameTotal];
	logic ledOn [frameTotal];
	rateT expRate [frameTotal];

	function automatic logic [31:0] lcgNext(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// direct-form 31-tap sum, zeros before the first sample
	function automatic sampleT firRef(input int k);
		int acc;
		int coef;
		acc = 0;
		for (int i = 0; i < firTaps; i++)
		begin
			coef = (i <= firTaps / 2) ? firCoefs[i] : firCoefs[firTaps - 1 - i];
			if (k - i >= 0)
				acc += coef * int'(samples[k - i]);
		end
		return sampleT'((acc & 32'h3ffff) >> firShift);
	endfunction

	// slope window model, half sums counted from scratch every frame
	function automatic void peakRef();
		logic [slopeWindow-1:0] win;
		sampleT prev;
		int left;
		int right;
		int hold;
		logic lit;
		win = '1;
		prev = '0;
		lit = 1'b0;
		hold = 0;
		for (int k = 0; k < frameTotal; k++)
		begin
			win = {win[slopeWindow-2:0], (firOut[k] <= prev)};
			prev = firOut[k];
			left = 0;
			right = 0;
			for (int b = 0; b < slopeWindow / 2; b++)
			begin
				left += int'(win[b + slopeWindow / 2]);
				right += int'(win[b]);
			end
			peakAt[k] = !lit && (left <= peakLeftMax) && (right >= peakRightMin);
			if (peakAt[k])
			begin
				lit = 1'b1;
				hold = 0;
			end
			else if (lit)
			begin
				if (hold == peakHoldFrames - 1)
					lit = 1'b0;
				else
					hold++;
			end
			ledOn[k] = lit;
		end
	endfunction

	// peaks in the window, one found on its last frame included
	function automatic rateT rateRef(input int lastFrame);
		int peaks;
		peaks = 0;
		for (int f = lastFrame - windowLen + 1; f <= lastFrame; f++)
			if (f >= 0 && peakAt[f])
				peaks++;
		return rateT'(peaks * ratePerPeak);
	endfunction

	always #5 sck = ~sck;

	// run limit
	always @(posedge sck)
	begin
		cycles <= cycles + 1;
		if (cycles == cycleLimit)
		begin
			$display("timeout after %0d cycles, checker never finished", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	heartRateMonitor #(
		.windowFrames(windowLen)
	) DUT (
		.sck(sck),
		.reset(reset),
		.sdo(sdo),
		.peakLed(peakLed),
		.dacPins(dacPins),
		.displayPins(displayPins)
	);

	heartRateChecker #(
		.frames(frameTotal),
		.windowLen(windowLen)
	) watch (
		.sck(sck),
		.reset(reset),
		.peakLed(peakLed),
		.dacPins(dacPins),
		.displayPins(displayPins),
		.expFir(firOut),
		.expLed(ledOn),
		.expRate(expRate),
		.done(done),
		.checks(checks),
		.errors(errors)
	);

	initial
	begin
		logic [31:0] seed;
		int pos;
		int rampLevel;
		rateT current;
		sck = 1'b0;
		reset = 1'b1;
		sdo = 1'b0;
		seed = 32'h7eaca25d;
		// triangle, period 300 frames, 2 bits of noise, junk in the top 6 bits
		for (int f = 0; f < frameTotal; f++)
		begin
			seed = lcgNext(seed);
			pos = f % 300;
			rampLevel = (pos < 150) ? pos : 300 - pos;
			samples[f] = sampleT'(16 + rampLevel * 7 / 5 + int'(seed[17:16]));
			words[f] = {seed[31:26], samples[f]};
		end
		for (int f = 0; f < frameTotal; f++)
			firOut[f] = firRef(f);
		peakRef();
		// rate shown after each frame
		current = '0;
		for (int k = 0; k < frameTotal; k++)
		begin
			if ((k + 1) % windowLen == 0)
				current = rateRef(k);
			expRate[k] = current;
		end

		repeat (resetCycles) @(posedge sck);
		reset <= 1'b0;
		// MSB first, each bit set up one edge ahead
		for (int f = 0; f < frameTotal; f++)
			for (int b = 0; b < frameBits; b++)
			begin
				sdo <= words[f][frameBits - 1 - b];
				@(posedge sck);
			end
		sdo <= 1'b0;

		wait (done);
		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verilog.f
source/dspPkg.sv
source/ioPkg.sv
source/spiSampleReceiver.sv
source/firFilter.sv
source/peakDetector.sv
source/dacSerializer.sv
source/rateCounter.sv
source/displayDriver.sv
source/heartRateMonitor.sv
sim/heartRateChecker.sv
sim/tbHeartRate.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
TOP = tbHeartRate
FILELIST = verilog.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the fail message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
